// ==== mips_core.f ====
common/mips_isa_pkg.sv
common/mips_pipe_pkg.sv
logic/reg_file.sv
logic/decode_ctrl.sv
logic/alu.sv
core/id_ex_reg.sv
core/mem_stage.sv
core/mips_core.sv
testbench/mips_core_properties.sv
testbench/tb_mips_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the mips_core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f mips_core.f \
	--top-module tb_mips_core --Mdir obj_dir -o sim_mips_core

if ./obj_dir/sim_mips_core | tee /dev/stderr | grep -F '*** PASSED ***' > /dev/null; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi

// ==== testbench/tb_mips_core.sv ====
`timescale 1ns/1ps

module tb_mips_core;
	import mips_isa_pkg::*;
	import mips_pipe_pkg::*;

	localparam int N_RANDOM       = 40;
	localparam int ROM_WORDS      = 256;
	localparam int MEM_WORDS      = 64;
	localparam int DUMP_BASE      = 56;
	localparam int TIMEOUT_CYCLES = N_RANDOM * 3 * 4 + 200;

	logic            clk;
	logic            rst_n;
	logic [XLEN-1:0] imem_addr;
	logic [XLEN-1:0] imem_data;
	wb_m2s_t         wb_m2s;
	wb_s2m_t         wb_s2m;

	logic [XLEN-1:0] rom [ROM_WORDS];
	logic [XLEN-1:0] mem [MEM_WORDS];
	logic [XLEN-1:0] iss_mem [MEM_WORDS];
	logic [XLEN-1:0] iss_regs [REG_COUNT];
	wb_m2s_t         exp_q [$];
	logic [XLEN-1:0] exp_load_q [$];
	logic [31:0]     rng;
	int              prog_len;
	int              iss_pc;
	int              n_seen = 0;
	int              cycle_count = 0;
	int              wait_left = 0;
	logic            in_wait = 1'b0;
	logic            mem_ack = 1'b0;
	logic [XLEN-1:0] mem_rdata = '0;
	logic            load_pending = 1'b0;
	logic [XLEN-1:0] load_exp = '0;

	initial clk = 1'b0;
	always #10 clk = ~clk;

	assign imem_data  = rom[imem_addr[9:2]];
	assign wb_s2m.ack = mem_ack;
	assign wb_s2m.dat = mem_rdata;

	mips_core i_dut (
		.clk      (clk),
		.rst_n    (rst_n),
		.imem_addr(imem_addr),
		.imem_data(imem_data),
		.wb_m2s   (wb_m2s),
		.wb_s2m   (wb_s2m)
	);

	//////////////////////////////////////////////////
	// Random numbers and encoding
	//////////////////////////////////////////////////

	function automatic logic [31:0] xorshift(logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic int unsigned rand_below(int unsigned n);
		rng = xorshift(rng);
		return rng % n;
	endfunction

	function automatic logic [31:0] enc_r(funct_e fn, int rs, int rt, int rd);
		return {op_rtype, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
	endfunction

	function automatic logic [31:0] enc_i(opcode_e op, int rs, int rt, logic [15:0] imm);
		return {op, rs[4:0], rt[4:0], imm};
	endfunction

	// Initial memory word built from the whole address
	function automatic logic [31:0] mem_fill(int i);
		logic [31:0] a;
		a = i;
		return ((a + 32'd1) * 32'h9e3779b9) ^ 32'h5a5a0000;
	endfunction

	//////////////////////////////////////////////////
	// Program generator
	//////////////////////////////////////////////////

	task automatic gen_program();
		int          n;
		int          rs;
		int          rt;
		int          rd;
		logic        writer;
		funct_e      fn;
		logic [15:0] imm;
		n = 0;
		for (int k = 0; k < N_RANDOM; k++)
		begin
			rs     = 1 + rand_below(7);
			rt     = 1 + rand_below(7);
			rd     = 1 + rand_below(7);
			writer = 1'b1;
			case (rand_below(6))
				0:
				begin
					case (rand_below(5))
						0: fn = fn_add;
						1: fn = fn_sub;
						2: fn = fn_and;
						3: fn = fn_or;
						default: fn = fn_slt;
					endcase
					rom[n] = enc_r(fn, rs, rt, rd);
				end
				1:
				begin
					rng = xorshift(rng);
					rom[n] = enc_i(op_addi, rs, rt, rng[15:0]);
				end
				2: rom[n] = enc_i(op_lw, 0, rt, 16'(4 * rand_below(MEM_WORDS)));
				3:
				begin
					rom[n] = enc_i(op_sw, 0, rt, 16'(4 * rand_below(MEM_WORDS)));
					writer = 1'b0;
				end
				// Forward branch over 1 to 3 words on any two of r0 to r7
				default:
				begin
					imm    = 16'(1 + rand_below(3));
					rs     = rand_below(8);
					rt     = rand_below(8);
					rom[n] = enc_i(rand_below(2) == 0 ? op_beq : op_bne, rs, rt, imm);
					writer = 1'b0;
				end
			endcase
			n = n + (writer ? 3 : 1);
		end
		// Landing pad for a late branch before the register dump
		n = n + 3;
		for (int r = 1; r <= 7; r++)
		begin
			rom[n] = enc_i(op_sw, 0, r, 16'(4 * (DUMP_BASE + r - 1)));
			n++;
		end
		rom[n]   = enc_i(op_beq, 0, 0, 16'hffff);
		prog_len = n + 1;
	endtask

	//////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////

	function automatic int iss_step(int idx);
		logic [31:0] w;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm_x;
		logic [31:0] res;
		logic [4:0]  dest;
		logic        wr;
		int          next;
		wb_m2s_t     acc;
		w     = rom[idx];
		a     = iss_regs[w[25:21]];
		b     = iss_regs[w[20:16]];
		imm_x = {{16{w[15]}}, w[15:0]};
		res   = '0;
		dest  = w[20:16];
		wr    = 1'b0;
		next  = idx + 1;
		acc   = '0;
		acc.sel = '1;
		acc.cyc = 1'b1;
		acc.stb = 1'b1;
		acc.adr = a + imm_x;
		case (opcode_e'(w[31:26]))
			op_rtype:
			begin
				dest = w[15:11];
				wr   = 1'b1;
				case (funct_e'(w[5:0]))
					fn_add: res = a + b;
					fn_sub: res = a - b;
					fn_and: res = a & b;
					fn_or:  res = a | b;
					fn_slt: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					default: wr = 1'b0;
				endcase
			end
			op_addi:
			begin
				res = a + imm_x;
				wr  = 1'b1;
			end
			op_lw:
			begin
				res = iss_mem[acc.adr[7:2]];
				wr  = 1'b1;
				exp_q.push_back(acc);
				exp_load_q.push_back(res);
			end
			op_sw:
			begin
				acc.dat = b;
				acc.we  = 1'b1;
				iss_mem[acc.adr[7:2]] = b;
				exp_q.push_back(acc);
			end
			op_beq:
				if (a == b)
					next = idx + 1 + int'($signed(w[15:0]));
			op_bne:
				if (a != b)
					next = idx + 1 + int'($signed(w[15:0]));
			default: wr = 1'b0;
		endcase
		if (wr && dest != 5'd0)
			iss_regs[dest] = res;
		return next;
	endfunction

	//////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////

	task automatic abort_run(string why);
		$display("%s", why);
		$display("*** FAILED ***");
		$fatal(1);
	endtask

	task automatic check_access(wb_m2s_t got, wb_m2s_t exp);
		if (got.adr !== exp.adr || got.we !== exp.we || (exp.we && got.dat !== exp.dat))
			abort_run($sformatf(
				"FAIL t=%0t: access %0d got adr %h we %b dat %h, exp adr %h we %b dat %h",
				$time, n_seen, got.adr, got.we, got.dat, exp.adr, exp.we, exp.dat));
	endtask

	task automatic check_load(logic [XLEN-1:0] got, logic [XLEN-1:0] exp);
		if (got !== exp)
			abort_run($sformatf("FAIL t=%0t: load %0d wrote back %h, expected %h",
				$time, n_seen - 1, got, exp));
	endtask

	// Wishbone slave with 0 to 3 random wait states
	// Each access is compared in the cycle it is acked
	always @(negedge clk)
	begin
		if (mem_ack)
		begin
			mem_ack = 1'b0;
			// The acked word has just entered the write-back record
			if (load_pending)
			begin
				check_load(i_dut.mem_wb.wb_data, load_exp);
				load_pending = 1'b0;
			end
		end
		else if (rst_n && wb_m2s.cyc)
		begin
			if (!in_wait)
			begin
				in_wait   = 1'b1;
				wait_left = rand_below(4);
			end
			if (wait_left == 0)
			begin
				if (exp_q.size() == 0)
					abort_run("Bus access seen after the reference model ran out of accesses");
				check_access(wb_m2s, exp_q.pop_front());
				if (wb_m2s.we)
					mem[wb_m2s.adr[7:2]] = wb_m2s.dat;
				else
				begin
					mem_rdata    = mem[wb_m2s.adr[7:2]];
					load_exp     = exp_load_q.pop_front();
					load_pending = 1'b1;
				end
				n_seen++;
				mem_ack = 1'b1;
				in_wait = 1'b0;
			end
			else
				wait_left--;
		end
	end

	always @(posedge clk)
		cycle_count++;

	always @(negedge clk)
		if (cycle_count > TIMEOUT_CYCLES)
			abort_run("Timeout: the core did not finish its bus accesses in time");

	//////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////

	initial
	begin
		rng   = 32'd39151;
		rst_n = 1'b0;
		for (int i = 0; i < ROM_WORDS; i++)
			rom[i] = '0;
		for (int i = 0; i < MEM_WORDS; i++)
		begin
			mem[i]     = mem_fill(i);
			iss_mem[i] = mem_fill(i);
		end
		for (int i = 0; i < REG_COUNT; i++)
			iss_regs[i] = '0;
		gen_program();
		iss_pc = 0;
		while (iss_pc != prog_len - 1)
			iss_pc = iss_step(iss_pc);
		repeat (3)
		begin
			@(negedge clk);
			if (imem_addr !== '0 || wb_m2s.cyc !== 1'b0 || wb_m2s.stb !== 1'b0)
				abort_run($sformatf("FAIL t=%0t: reset state pc %h cyc %b stb %b",
					$time, imem_addr, wb_m2s.cyc, wb_m2s.stb));
		end
		rst_n = 1'b1;
		while (exp_q.size() != 0)
			@(negedge clk);
		// Room for any access beyond the expected list
		repeat (20) @(negedge clk);
		if (exp_q.size() == 0 && exp_load_q.size() == 0)
		begin
			$display("*** PASSED ***");
			$finish;
		end
		else
			abort_run("Reference accesses left unmatched at the end of the run");
	end

endmodule

// ==== testbench/mips_core_properties.sv ====
`timescale 1ns/1ps

module mips_core_properties (
	input logic                   clk,
	input logic                   rst_n,
	input mips_pipe_pkg::wb_m2s_t wb_m2s,
	input mips_pipe_pkg::wb_s2m_t wb_s2m
);
	import mips_pipe_pkg::*;

	// Request held steady until the slave answers
	property req_steady;
		@(posedge clk) disable iff (!rst_n)
		(wb_m2s.cyc && !wb_s2m.ack) |=> (wb_m2s.cyc && $stable(wb_m2s.adr) &&
			$stable(wb_m2s.dat) && $stable(wb_m2s.we));
	endproperty

	property stb_is_cyc;
		@(posedge clk) disable iff (!rst_n)
		(wb_m2s.stb == wb_m2s.cyc) && (wb_m2s.sel == {SEL_W{1'b1}});
	endproperty

	// Single-cycle classic, cycle ends right after ack
	property drop_after_ack;
		@(posedge clk) disable iff (!rst_n)
		(wb_m2s.cyc && wb_s2m.ack) |=> !wb_m2s.cyc;
	endproperty

	a_req_steady:     assert property (req_steady) else $error("request changed before ack");
	a_stb_is_cyc:     assert property (stb_is_cyc) else $error("stb or sel out of step with cyc");
	a_drop_after_ack: assert property (drop_after_ack) else $error("cyc still high after ack");

endmodule

bind mips_core mips_core_properties u_props (
	.clk   (clk),
	.rst_n (rst_n),
	.wb_m2s(wb_m2s),
	.wb_s2m(wb_s2m)
);

// ==== core/mips_core.sv ====
`timescale 1ns/1ps

module mips_core (
	input  logic                           clk,
	input  logic                           rst_n,
	output logic [mips_pipe_pkg::XLEN-1:0] imem_addr,
	input  logic [mips_pipe_pkg::XLEN-1:0] imem_data,
	output mips_pipe_pkg::wb_m2s_t         wb_m2s,
	input  mips_pipe_pkg::wb_s2m_t         wb_s2m
);
	import mips_isa_pkg::*;
	import mips_pipe_pkg::*;

	logic [XLEN-1:0] pc;
	logic [XLEN-1:0] pc_plus4;
	logic [XLEN-1:0] if_instr;
	logic [XLEN-1:0] if_pc_plus4;
	ctrl_t           id_ctrl;
	logic [XLEN-1:0] id_sign_ext;
	logic [XLEN-1:0] id_rd1;
	logic [XLEN-1:0] id_rd2;
	id_ex_t          id_ex_d;
	id_ex_t          id_ex_q;
	logic [XLEN-1:0] alu_b;
	logic [XLEN-1:0] alu_result;
	logic            alu_zero;
	logic            branch_taken;
	logic [XLEN-1:0] branch_target;
	ex_mem_t         ex_rec;
	mem_wb_t         mem_wb;
	logic            stall;

	//////////////////////////////////////////////////
	// Fetch
	//////////////////////////////////////////////////

	assign imem_addr = pc;
	assign pc_plus4  = pc + PC_STEP;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			pc <= RESET_PC;
		else if (!stall)
			pc <= branch_taken ? branch_target : pc_plus4;
	end

	// Fetch-to-decode register, a zero word is the bubble
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			if_instr <= '0;
		else if (!stall)
		begin
			if_instr    <= branch_taken ? '0 : imem_data;
			if_pc_plus4 <= pc_plus4;
		end
	end

	//////////////////////////////////////////////////
	// Decode
	//////////////////////////////////////////////////

	decode_ctrl u_decode (.instr(if_instr), .ctrl(id_ctrl), .sign_ext(id_sign_ext));

	reg_file u_regs (
		.clk        (clk),
		.rst_n      (rst_n),
		.rs_addr    (if_instr[RS_LSB +: REG_AW]),
		.rt_addr    (if_instr[RT_LSB +: REG_AW]),
		.read_data_1(id_rd1),
		.read_data_2(id_rd2),
		.wb         (mem_wb)
	);

	always_comb
	begin
		id_ex_d.pc_plus4    = if_pc_plus4;
		id_ex_d.read_data_1 = id_rd1;
		id_ex_d.read_data_2 = id_rd2;
		id_ex_d.sign_ext    = id_sign_ext;
		id_ex_d.rt          = if_instr[RT_LSB +: REG_AW];
		id_ex_d.rd          = if_instr[RD_LSB +: REG_AW];
		id_ex_d.ctrl        = id_ctrl;
	end

	id_ex_reg u_id_ex (
		.clk  (clk),
		.rst_n(rst_n),
		.stall(stall),
		.flush(branch_taken),
		.d    (id_ex_d),
		.q    (id_ex_q)
	);

	//////////////////////////////////////////////////
	// Execute
	//////////////////////////////////////////////////

	assign alu_b = id_ex_q.ctrl.alu_src ? id_ex_q.sign_ext : id_ex_q.read_data_2;

	alu u_alu (
		.op    (id_ex_q.ctrl.alu_op),
		.a     (id_ex_q.read_data_1),
		.b     (alu_b),
		.result(alu_result),
		.zero  (alu_zero)
	);

	// Word offset relative to the next instruction
	assign branch_target = id_ex_q.pc_plus4 + (id_ex_q.sign_ext << 2);
	assign branch_taken  = (id_ex_q.ctrl.branch_eq && alu_zero) ||
		(id_ex_q.ctrl.branch_ne && !alu_zero);

	always_comb
	begin
		ex_rec.alu_result = alu_result;
		ex_rec.store_data = id_ex_q.read_data_2;
		ex_rec.dest       = id_ex_q.ctrl.reg_dest ? id_ex_q.rd : id_ex_q.rt;
		ex_rec.mem_read   = id_ex_q.ctrl.mem_read;
		ex_rec.mem_write  = id_ex_q.ctrl.mem_write;
		ex_rec.mem_to_reg = id_ex_q.ctrl.mem_to_reg;
		ex_rec.reg_write  = id_ex_q.ctrl.reg_write;
	end

	mem_stage u_mem (
		.clk   (clk),
		.rst_n (rst_n),
		.ex    (ex_rec),
		.wb_m2s(wb_m2s),
		.wb_s2m(wb_s2m),
		.mem_wb(mem_wb),
		.stall (stall)
	);

endmodule

// ==== core/mem_stage.sv ====
`timescale 1ns/1ps

module mem_stage (
	input  logic                   clk,
	input  logic                   rst_n,
	input  mips_pipe_pkg::ex_mem_t ex,
	output mips_pipe_pkg::wb_m2s_t wb_m2s,
	input  mips_pipe_pkg::wb_s2m_t wb_s2m,
	output mips_pipe_pkg::mem_wb_t mem_wb,
	output logic                   stall
);
	import mips_pipe_pkg::*;

	typedef enum logic {
		st_idle,
		st_wait_ack
	} bus_state_e;

	bus_state_e state;
	bus_state_e state_nxt;
	ex_mem_t    ex_mem_q;
	logic       mem_op_q;
	logic       mem_op_in;

	assign mem_op_q  = ex_mem_q.mem_read || ex_mem_q.mem_write;
	assign mem_op_in = ex.mem_read || ex.mem_write;

	//////////////////////////////////////////////////
	// Bus sequencing
	//////////////////////////////////////////////////

	// An access left in idle was loaded right behind an ack and goes out one cycle late
	always_comb
	begin
		state_nxt = state;
		case (state)
			st_idle:
				if (mem_op_q || mem_op_in)
					state_nxt = st_wait_ack;
			st_wait_ack:
				if (wb_s2m.ack)
					state_nxt = st_idle;
			default: state_nxt = st_idle;
		endcase
	end

	assign stall = (state == st_wait_ack) ? !wb_s2m.ack : mem_op_q;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state    <= st_idle;
			ex_mem_q <= '0;
		end
		else
		begin
			state <= state_nxt;
			if (!stall)
				ex_mem_q <= ex;
		end
	end

	assign wb_m2s.adr = ex_mem_q.alu_result;
	assign wb_m2s.dat = ex_mem_q.store_data;
	assign wb_m2s.sel = {SEL_W{1'b1}};
	assign wb_m2s.we  = ex_mem_q.mem_write;
	assign wb_m2s.cyc = (state == st_wait_ack);
	assign wb_m2s.stb = (state == st_wait_ack);

	//////////////////////////////////////////////////
	// Write-back record
	//////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			mem_wb <= '0;
		else if (stall)
			mem_wb.reg_write <= 1'b0;
		else
		begin
			mem_wb.wb_data   <= ex_mem_q.mem_to_reg ? wb_s2m.dat : ex_mem_q.alu_result;
			mem_wb.dest      <= ex_mem_q.dest;
			mem_wb.reg_write <= ex_mem_q.reg_write;
		end
	end

endmodule

// ==== core/id_ex_reg.sv ====
`timescale 1ns/1ps

module id_ex_reg (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  stall,
	input  logic                  flush,
	input  mips_pipe_pkg::id_ex_t d,
	output mips_pipe_pkg::id_ex_t q
);
	import mips_pipe_pkg::*;

	id_ex_t d_next;

	// Squashed instruction keeps its operands but loses every enable
	always_comb
	begin
		d_next = d;
		if (flush)
			d_next.ctrl = '0;
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			q.ctrl <= '0;
		else if (!stall)
			q <= d_next;
	end

endmodule

// ==== logic/alu.sv ====
`timescale 1ns/1ps

module alu (
	input  mips_isa_pkg::alu_op_e          op,
	input  logic [mips_pipe_pkg::XLEN-1:0] a,
	input  logic [mips_pipe_pkg::XLEN-1:0] b,
	output logic [mips_pipe_pkg::XLEN-1:0] result,
	output logic                           zero
);
	import mips_isa_pkg::*;
	import mips_pipe_pkg::*;

	logic less;

	// Signed compare for slt
	assign less = $signed(a) < $signed(b);

	always_comb
	begin
		case (op)
			alu_add: result = a + b;
			alu_sub: result = a - b;
			alu_and: result = a & b;
			alu_or:  result = a | b;
			alu_slt: result = {{(XLEN-1){1'b0}}, less};
			default: result = '0;
		endcase
	end

	// Drives the beq / bne decision
	assign zero = (result == '0);

endmodule

// ==== logic/decode_ctrl.sv ====
`timescale 1ns/1ps

module decode_ctrl (
	input  logic [mips_pipe_pkg::XLEN-1:0] instr,
	output mips_pipe_pkg::ctrl_t           ctrl,
	output logic [mips_pipe_pkg::XLEN-1:0] sign_ext
);
	import mips_isa_pkg::*;
	import mips_pipe_pkg::*;

	opcode_e opcode;
	funct_e  funct;

	assign opcode   = opcode_e'(instr[OP_LSB +: OP_W]);
	assign funct    = funct_e'(instr[FN_W-1:0]);
	assign sign_ext = {{(XLEN-IMM_W){instr[IMM_W-1]}}, instr[IMM_W-1:0]};

	always_comb
	begin
		ctrl = '0;
		case (opcode)
			op_rtype:
			begin
				ctrl.reg_dest  = 1'b1;
				ctrl.reg_write = 1'b1;
				case (funct)
					fn_add: ctrl.alu_op = alu_add;
					fn_sub: ctrl.alu_op = alu_sub;
					fn_and: ctrl.alu_op = alu_and;
					fn_or:  ctrl.alu_op = alu_or;
					fn_slt: ctrl.alu_op = alu_slt;
					// Unknown function, also the all-zero word
					default: ctrl = '0;
				endcase
			end
			op_addi:
			begin
				ctrl.alu_src   = 1'b1;
				ctrl.reg_write = 1'b1;
			end
			op_lw:
			begin
				ctrl.alu_src    = 1'b1;
				ctrl.mem_read   = 1'b1;
				ctrl.mem_to_reg = 1'b1;
				ctrl.reg_write  = 1'b1;
			end
			op_sw:
			begin
				ctrl.alu_src   = 1'b1;
				ctrl.mem_write = 1'b1;
			end
			// Branches compare with a subtract
			op_beq:
			begin
				ctrl.alu_op    = alu_sub;
				ctrl.branch_eq = 1'b1;
			end
			op_bne:
			begin
				ctrl.alu_op    = alu_sub;
				ctrl.branch_ne = 1'b1;
			end
			default: ctrl = '0;
		endcase
	end

endmodule

// ==== logic/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic [mips_pipe_pkg::REG_AW-1:0] rs_addr,
	input  logic [mips_pipe_pkg::REG_AW-1:0] rt_addr,
	output logic [mips_pipe_pkg::XLEN-1:0]   read_data_1,
	output logic [mips_pipe_pkg::XLEN-1:0]   read_data_2,
	input  mips_pipe_pkg::mem_wb_t           wb
);
	import mips_pipe_pkg::*;

	logic [XLEN-1:0] regs [REG_COUNT];

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < REG_COUNT; i++)
				regs[i] <= '0;
		end
		else if (wb.reg_write && wb.dest != '0)
			regs[wb.dest] <= wb.wb_data;
	end

	// Register 0 first, then bypass of the write in progress
	assign read_data_1 = (rs_addr == '0) ? '0 :
		(wb.reg_write && wb.dest == rs_addr) ? wb.wb_data : regs[rs_addr];
	assign read_data_2 = (rt_addr == '0) ? '0 :
		(wb.reg_write && wb.dest == rt_addr) ? wb.wb_data : regs[rt_addr];

endmodule

// ==== common/mips_pipe_pkg.sv ====
package mips_pipe_pkg;

	//////////////////////////////////////////////////
	// Pipeline dimensions
	//////////////////////////////////////////////////

	localparam int XLEN      = 32;
	localparam int REG_COUNT = 32;
	localparam int REG_AW    = $clog2(REG_COUNT);
	localparam int SEL_W     = XLEN / 8;
	localparam int PC_STEP   = 4;

	localparam logic [XLEN-1:0] RESET_PC = '0;

	// Decoded control bits, all zero is a no-op
	typedef struct packed {
		logic                  reg_dest;
		logic                  alu_src;
		mips_isa_pkg::alu_op_e alu_op;
		logic                  branch_eq;
		logic                  branch_ne;
		logic                  mem_read;
		logic                  mem_write;
		logic                  mem_to_reg;
		logic                  reg_write;
	} ctrl_t;

	//////////////////////////////////////////////////
	// Stage records
	//////////////////////////////////////////////////

	typedef struct packed {
		logic [XLEN-1:0]   pc_plus4;
		logic [XLEN-1:0]   read_data_1;
		logic [XLEN-1:0]   read_data_2;
		logic [XLEN-1:0]   sign_ext;
		logic [REG_AW-1:0] rt;
		logic [REG_AW-1:0] rd;
		ctrl_t             ctrl;
	} id_ex_t;

	typedef struct packed {
		logic [XLEN-1:0]   alu_result;
		logic [XLEN-1:0]   store_data;
		logic [REG_AW-1:0] dest;
		logic              mem_read;
		logic              mem_write;
		logic              mem_to_reg;
		logic              reg_write;
	} ex_mem_t;

	typedef struct packed {
		logic [XLEN-1:0]   wb_data;
		logic [REG_AW-1:0] dest;
		logic              reg_write;
	} mem_wb_t;

	//////////////////////////////////////////////////
	// Wishbone classic
	//////////////////////////////////////////////////

	typedef struct packed {
		logic [XLEN-1:0]  adr;
		logic [XLEN-1:0]  dat;
		logic [SEL_W-1:0] sel;
		logic             we;
		logic             cyc;
		logic             stb;
	} wb_m2s_t;

	typedef struct packed {
		logic [XLEN-1:0] dat;
		logic            ack;
	} wb_s2m_t;

endpackage

// ==== common/mips_isa_pkg.sv ====
package mips_isa_pkg;

	//////////////////////////////////////////////////
	// Instruction word layout
	//////////////////////////////////////////////////

	localparam int OP_LSB = 26;
	localparam int OP_W   = 6;
	localparam int RS_LSB = 21;
	localparam int RT_LSB = 16;
	localparam int RD_LSB = 11;
	localparam int FN_W   = 6;
	localparam int IMM_W  = 16;

	// Primary opcodes, bits 31:26
	typedef enum logic [OP_W-1:0] {
		op_rtype = 6'h00,
		op_beq   = 6'h04,
		op_bne   = 6'h05,
		op_addi  = 6'h08,
		op_lw    = 6'h23,
		op_sw    = 6'h2b
	} opcode_e;

	// Function field of R-type words
	typedef enum logic [FN_W-1:0] {
		fn_add = 6'h20,
		fn_sub = 6'h22,
		fn_and = 6'h24,
		fn_or  = 6'h25,
		fn_slt = 6'h2a
	} funct_e;

	// ALU operations, add must stay zero so a cleared struct selects it
	typedef enum logic [2:0] {
		alu_add = 3'd0,
		alu_sub = 3'd1,
		alu_and = 3'd2,
		alu_or  = 3'd3,
		alu_slt = 3'd4
	} alu_op_e;

endpackage
